// ==== verilog/alu_other_pkg.sv ====
package alu_other_pkg;

  // vector and scalar widths
  localparam int VLEN  = 128;
  localparam int XLEN  = 32;
  localparam int VLENB = VLEN / 8;

  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;

  localparam int ROB_ENTRY_WIDTH = 4;
  localparam int UOP_INDEX_WIDTH = 3;
  localparam int REG_INDEX_WIDTH = 5;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVX = 3'b100
  } funct3_e;

  localparam int FUNCT6_WIDTH = 6;

  localparam logic [FUNCT6_WIDTH-1:0] VMINU      = 6'b000100;
  localparam logic [FUNCT6_WIDTH-1:0] VMIN       = 6'b000101;
  localparam logic [FUNCT6_WIDTH-1:0] VMAXU      = 6'b000110;
  localparam logic [FUNCT6_WIDTH-1:0] VMAX       = 6'b000111;
  localparam logic [FUNCT6_WIDTH-1:0] VMERGE_VMV = 6'b010111;
  localparam logic [FUNCT6_WIDTH-1:0] VXUNARY0   = 6'b010010;

  // vs1 field under VXUNARY0, low bit selects sign extension
  localparam logic [REG_INDEX_WIDTH-1:0] VZEXT_VF4 = 5'b00100;
  localparam logic [REG_INDEX_WIDTH-1:0] VSEXT_VF4 = 5'b00101;
  localparam logic [REG_INDEX_WIDTH-1:0] VZEXT_VF2 = 5'b00110;
  localparam logic [REG_INDEX_WIDTH-1:0] VSEXT_VF2 = 5'b00111;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_MINMAX = 3'd1,
    OP_MERGE  = 3'd2,
    OP_MOVE   = 3'd3,
    OP_EXTEND = 3'd4
  } alu_op_e;

  // one register seen as bytes, halfwords or words
  typedef union packed {
    logic [VLENB-1:0][BYTE_WIDTH-1:0]              b;
    logic [VLEN/HWORD_WIDTH-1:0][HWORD_WIDTH-1:0]  h;
    logic [VLEN/WORD_WIDTH-1:0][WORD_WIDTH-1:0]    w;
  } vreg_u;

endpackage

// ==== verilog/uop_ctrl_if.sv ====
`timescale 1ns/1ps

interface uop_ctrl_if;
  import alu_other_pkg::*;

  alu_op_e op;
  eew_e    eew;
  logic    is_signed;
  logic    is_max;
  logic    use_scalar;
  // factor-4 extension
  logic    ext_quarter;
  logic    legal;

  modport ctrl (output op, eew, is_signed, is_max, use_scalar, ext_quarter, legal);

  modport dp (input op, eew, is_signed, is_max, use_scalar, ext_quarter, legal);

endinterface

// ==== verilog/alu_other_decode.sv ====
`timescale 1ns/1ps

module alu_other_decode (
  input  alu_other_pkg::funct3_e                          funct3,
  input  logic [alu_other_pkg::FUNCT6_WIDTH-1:0]          funct6,
  input  logic [alu_other_pkg::REG_INDEX_WIDTH-1:0]       vs1,
  input  logic                                            vm,
  input  alu_other_pkg::eew_e                             vs2_eew,
  uop_ctrl_if.ctrl                                        ctrl
);
  import alu_other_pkg::*;

  logic width_fits;

  always_comb begin
    ctrl.op          = OP_NONE;
    ctrl.eew         = vs2_eew;
    ctrl.is_signed   = 1'b0;
    ctrl.is_max      = 1'b0;
    ctrl.use_scalar  = (funct3 == OPIVX);
    ctrl.ext_quarter = 1'b0;
    width_fits       = vs2_eew inside {EEW8, EEW16, EEW32};

    if (funct3 == OPIVV || funct3 == OPIVX) begin
      case (funct6)
        VMINU, VMIN, VMAXU, VMAX: begin
          ctrl.op        = OP_MINMAX;
          ctrl.is_signed = funct6[0];
          ctrl.is_max    = funct6[1];
        end
        VMERGE_VMV: begin
          // unmasked form is a plain move
          ctrl.op = vm ? OP_MOVE : OP_MERGE;
        end
        default: ;
      endcase
    end else if (funct3 == OPMVV && funct6 == VXUNARY0) begin
      case (vs1)
        VZEXT_VF4, VSEXT_VF4: begin
          ctrl.op          = OP_EXTEND;
          ctrl.ext_quarter = 1'b1;
          ctrl.is_signed   = vs1[0];
          width_fits       = (vs2_eew == EEW8);
        end
        VZEXT_VF2, VSEXT_VF2: begin
          ctrl.op        = OP_EXTEND;
          ctrl.is_signed = vs1[0];
          width_fits     = (vs2_eew == EEW8) || (vs2_eew == EEW16);
        end
        default: ;
      endcase
    end

    ctrl.legal = (ctrl.op != OP_NONE) && width_fits;
    // illegal uops leave no operation for the datapath
    if (!ctrl.legal) begin
      ctrl.op = OP_NONE;
    end

    assert (!(ctrl.op == OP_EXTEND && ctrl.ext_quarter) || ctrl.eew == EEW8)
      else $error("factor-4 extension decoded at element width above 8");
  end

endmodule

// ==== verilog/alu_operand_prep.sv ====
`timescale 1ns/1ps

module alu_operand_prep (
  uop_ctrl_if.dp                         ctrl,
  input  alu_other_pkg::vreg_u           vs1_data,
  input  logic [alu_other_pkg::XLEN-1:0] rs1_data,
  output alu_other_pkg::vreg_u           src1
);
  import alu_other_pkg::*;

  always_comb begin
    src1 = vs1_data;

    // scalar forms splat rs1 at the element width
    if (ctrl.use_scalar) begin
      case (ctrl.eew)
        EEW8: begin
          for (int i = 0; i < VLENB; i++) begin
            src1.b[i] = rs1_data[BYTE_WIDTH-1:0];
          end
        end
        EEW16: begin
          for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
            src1.h[i] = rs1_data[HWORD_WIDTH-1:0];
          end
        end
        EEW32: begin
          for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
            src1.w[i] = rs1_data[WORD_WIDTH-1:0];
          end
        end
        default: src1 = '0;
      endcase
    end
  end

endmodule

// ==== verilog/alu_minmax.sv ====
`timescale 1ns/1ps

module alu_minmax (
  uop_ctrl_if.dp               ctrl,
  input  alu_other_pkg::vreg_u src1,
  input  alu_other_pkg::vreg_u src2,
  output alu_other_pkg::vreg_u result
);
  import alu_other_pkg::*;

  // one extra bit on top, filled with the sign only for signed compares
  function automatic logic [WORD_WIDTH:0] f_widen(
    input logic [WORD_WIDTH-1:0] v,
    input int                    bits,
    input logic                  sgn
  );
    logic [WORD_WIDTH:0] w;
    logic                fill;
    w    = {1'b0, v};
    fill = sgn & v[bits-1];
    for (int k = 0; k <= WORD_WIDTH; k++) begin
      if (k >= bits && fill) begin
        w[k] = 1'b1;
      end
    end
    return w;
  endfunction

  function automatic logic [WORD_WIDTH-1:0] f_min_max(
    input logic signed [WORD_WIDTH:0] a,
    input logic signed [WORD_WIDTH:0] b,
    input logic                       get_max
  );
    logic a_lt_b;
    a_lt_b = a < b;
    return (a_lt_b ^ get_max) ? a[WORD_WIDTH-1:0] : b[WORD_WIDTH-1:0];
  endfunction

  always_comb begin
    result = '0;
    case (ctrl.eew)
      EEW8: begin
        for (int i = 0; i < VLENB; i++) begin
          result.b[i] = BYTE_WIDTH'(f_min_max(
            f_widen(WORD_WIDTH'(src2.b[i]), BYTE_WIDTH, ctrl.is_signed),
            f_widen(WORD_WIDTH'(src1.b[i]), BYTE_WIDTH, ctrl.is_signed),
            ctrl.is_max));
        end
      end
      EEW16: begin
        for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
          result.h[i] = HWORD_WIDTH'(f_min_max(
            f_widen(WORD_WIDTH'(src2.h[i]), HWORD_WIDTH, ctrl.is_signed),
            f_widen(WORD_WIDTH'(src1.h[i]), HWORD_WIDTH, ctrl.is_signed),
            ctrl.is_max));
        end
      end
      EEW32: begin
        for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
          result.w[i] = f_min_max(
            f_widen(src2.w[i], WORD_WIDTH, ctrl.is_signed),
            f_widen(src1.w[i], WORD_WIDTH, ctrl.is_signed),
            ctrl.is_max);
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/alu_extend.sv ====
`timescale 1ns/1ps

module alu_extend (
  uop_ctrl_if.dp                                    ctrl,
  input  logic [alu_other_pkg::UOP_INDEX_WIDTH-1:0] uop_index,
  input  alu_other_pkg::vreg_u                      src2,
  output alu_other_pkg::vreg_u                      result
);
  import alu_other_pkg::*;

  logic [VLEN/2-1:0]      half;
  logic [VLEN/4-1:0]      quarter;
  logic [BYTE_WIDTH-1:0]  elem8;
  logic [HWORD_WIDTH-1:0] elem16;

  // source slice for this uop
  assign half    = src2.w[2*uop_index[0] +: 2];
  assign quarter = src2.w[uop_index[1:0]];

  always_comb begin
    result = '0;
    elem8  = '0;
    elem16 = '0;
    if (ctrl.ext_quarter) begin
      for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
        elem8       = quarter[i*BYTE_WIDTH +: BYTE_WIDTH];
        result.w[i] = {{(WORD_WIDTH-BYTE_WIDTH){ctrl.is_signed & elem8[BYTE_WIDTH-1]}}, elem8};
      end
    end else begin
      case (ctrl.eew)
        EEW8: begin
          for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
            elem8       = half[i*BYTE_WIDTH +: BYTE_WIDTH];
            result.h[i] = {{(HWORD_WIDTH-BYTE_WIDTH){ctrl.is_signed & elem8[BYTE_WIDTH-1]}},
                           elem8};
          end
        end
        EEW16: begin
          for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
            elem16      = half[i*HWORD_WIDTH +: HWORD_WIDTH];
            result.w[i] = {{(WORD_WIDTH-HWORD_WIDTH){ctrl.is_signed & elem16[HWORD_WIDTH-1]}},
                           elem16};
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== verilog/alu_merge.sv ====
`timescale 1ns/1ps

module alu_merge (
  uop_ctrl_if.dp                                    ctrl,
  input  logic [alu_other_pkg::UOP_INDEX_WIDTH-1:0] uop_index,
  input  alu_other_pkg::vreg_u                      v0_data,
  input  alu_other_pkg::vreg_u                      src1,
  input  alu_other_pkg::vreg_u                      src2,
  output alu_other_pkg::vreg_u                      result
);
  import alu_other_pkg::*;

  logic [VLEN-1:0]  v0_flat;
  logic [VLENB-1:0] mask;

  assign v0_flat = v0_data;

  // mask bits for the elements covered by this uop
  always_comb begin
    case (ctrl.eew)
      EEW8:    mask = v0_flat[uop_index*VLENB +: VLENB];
      EEW16:   mask = VLENB'(v0_flat[uop_index*(VLEN/HWORD_WIDTH) +: VLEN/HWORD_WIDTH]);
      EEW32:   mask = VLENB'(v0_flat[uop_index*(VLEN/WORD_WIDTH) +: VLEN/WORD_WIDTH]);
      default: mask = '0;
    endcase
  end

  always_comb begin
    result = src2;
    case (ctrl.eew)
      EEW8: begin
        for (int i = 0; i < VLENB; i++) begin
          result.b[i] = mask[i] ? src1.b[i] : src2.b[i];
        end
      end
      EEW16: begin
        for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
          result.h[i] = mask[i] ? src1.h[i] : src2.h[i];
        end
      end
      EEW32: begin
        for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
          result.w[i] = mask[i] ? src1.w[i] : src2.w[i];
        end
      end
      default: result = '0;
    endcase
  end

endmodule

// ==== verilog/alu_result_stage.sv ====
`timescale 1ns/1ps

module alu_result_stage (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      uop_valid,
  input  logic [alu_other_pkg::ROB_ENTRY_WIDTH-1:0] rob_entry,
  uop_ctrl_if.dp                                    ctrl,
  input  alu_other_pkg::vreg_u                      src1,
  input  alu_other_pkg::vreg_u                      minmax_result,
  input  alu_other_pkg::vreg_u                      extend_result,
  input  alu_other_pkg::vreg_u                      merge_result,
  output logic                                      result_valid,
  output logic [alu_other_pkg::ROB_ENTRY_WIDTH-1:0] result_rob_entry,
  output alu_other_pkg::vreg_u                      result_data
);
  import alu_other_pkg::*;

  vreg_u result_sel;

  always_comb begin
    case (ctrl.op)
      OP_MINMAX: result_sel = minmax_result;
      OP_MERGE:  result_sel = merge_result;
      OP_MOVE:   result_sel = src1;
      OP_EXTEND: result_sel = extend_result;
      default:   result_sel = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid     <= 1'b0;
      result_rob_entry <= '0;
      result_data      <= '0;
    end else begin
      result_valid <= uop_valid & ctrl.legal;
      if (uop_valid) begin
        result_rob_entry <= rob_entry;
        result_data      <= result_sel;
      end
    end
  end

  // a result only leaves for a uop the decoder accepted
  assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(ctrl.op) != OP_NONE)
    else $error("result valid for a uop decoded as no operation");

endmodule

// ==== verilog/alu_other_unit.sv ====
`timescale 1ns/1ps

module alu_other_unit (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      uop_valid,
  input  logic                                      vm,
  input  alu_other_pkg::funct3_e                    funct3,
  input  logic [alu_other_pkg::FUNCT6_WIDTH-1:0]    funct6,
  input  logic [alu_other_pkg::REG_INDEX_WIDTH-1:0] vs1,
  input  alu_other_pkg::eew_e                       vs2_eew,
  input  logic [alu_other_pkg::UOP_INDEX_WIDTH-1:0] uop_index,
  input  logic [alu_other_pkg::ROB_ENTRY_WIDTH-1:0] rob_entry,
  input  logic [alu_other_pkg::VLEN-1:0]            v0_data,
  input  logic [alu_other_pkg::VLEN-1:0]            vs1_data,
  input  logic [alu_other_pkg::VLEN-1:0]            vs2_data,
  input  logic [alu_other_pkg::XLEN-1:0]            rs1_data,
  output logic                                      result_valid,
  output logic [alu_other_pkg::ROB_ENTRY_WIDTH-1:0] result_rob_entry,
  output logic [alu_other_pkg::VLEN-1:0]            result_data
);
  import alu_other_pkg::*;

  vreg_u src1;
  vreg_u minmax_result;
  vreg_u extend_result;
  vreg_u merge_result;
  vreg_u result_reg;

  uop_ctrl_if ctrl_if ();

  alu_other_decode u_decode (
    .funct3  (funct3),
    .funct6  (funct6),
    .vs1     (vs1),
    .vm      (vm),
    .vs2_eew (vs2_eew),
    .ctrl    (ctrl_if.ctrl)
  );

  alu_operand_prep u_operand_prep (
    .ctrl     (ctrl_if.dp),
    .vs1_data (vs1_data),
    .rs1_data (rs1_data),
    .src1     (src1)
  );

  alu_minmax u_minmax (
    .ctrl   (ctrl_if.dp),
    .src1   (src1),
    .src2   (vs2_data),
    .result (minmax_result)
  );

  alu_extend u_extend (
    .ctrl      (ctrl_if.dp),
    .uop_index (uop_index),
    .src2      (vs2_data),
    .result    (extend_result)
  );

  alu_merge u_merge (
    .ctrl      (ctrl_if.dp),
    .uop_index (uop_index),
    .v0_data   (v0_data),
    .src1      (src1),
    .src2      (vs2_data),
    .result    (merge_result)
  );

  alu_result_stage u_result_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .rob_entry        (rob_entry),
    .ctrl             (ctrl_if.dp),
    .src1             (src1),
    .minmax_result    (minmax_result),
    .extend_result    (extend_result),
    .merge_result     (merge_result),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_reg)
  );

  assign result_data = result_reg;

endmodule

// ==== verif/alu_other_tb.sv ====
`timescale 1ns/1ps

module alu_other_tb;
  import alu_other_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  logic                       vm;
  funct3_e                    funct3;
  logic [FUNCT6_WIDTH-1:0]    funct6;
  logic [REG_INDEX_WIDTH-1:0] vs1;
  eew_e                       vs2_eew;
  logic [UOP_INDEX_WIDTH-1:0] uop_index;
  logic [ROB_ENTRY_WIDTH-1:0] rob_entry;
  vreg_u                      v0_data;
  vreg_u                      vs1_data;
  vreg_u                      vs2_data;
  logic [XLEN-1:0]            rs1_data;
  logic                       result_valid;
  logic [ROB_ENTRY_WIDTH-1:0] result_rob_entry;
  vreg_u                      result_data;

  integer                     seed = 32'had1a_1ab7;
  int                         cycles;
  int                         checks;
  int                         errors;
  int                         tests_run;
  int                         tests_failed;
  logic [ROB_ENTRY_WIDTH-1:0] next_rob;

  alu_other_unit uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .vm               (vm),
    .funct3           (funct3),
    .funct6           (funct6),
    .vs1              (vs1),
    .vs2_eew          (vs2_eew),
    .uop_index        (uop_index),
    .rob_entry        (rob_entry),
    .v0_data          (v0_data),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rs1_data         (rs1_data),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int elem_bits(input eew_e e);
    return BYTE_WIDTH << int'(e);
  endfunction

  function automatic int elem_count(input eew_e e);
    return VLEN / elem_bits(e);
  endfunction

  function automatic logic [31:0] get_elem(input vreg_u r, input eew_e e, input int i);
    case (e)
      EEW8:    return 32'(r.b[i]);
      EEW16:   return 32'(r.h[i]);
      default: return r.w[i];
    endcase
  endfunction

  function automatic vreg_u set_elem(input vreg_u r, input eew_e e, input int i,
                                     input logic [31:0] v);
    vreg_u t;
    t = r;
    case (e)
      EEW8:    t.b[i] = v[7:0];
      EEW16:   t.h[i] = v[15:0];
      default: t.w[i] = v;
    endcase
    return t;
  endfunction

  // sign or zero extension of a narrow value to 32 bits
  function automatic logic [31:0] widen(input logic [31:0] v, input int bits, input logic sgn);
    if (sgn) begin
      return $signed(v << (32 - bits)) >>> (32 - bits);
    end
    return v;
  endfunction

  function automatic logic [31:0] pick(input logic [31:0] x, input logic [31:0] y,
                                       input int bits, input logic sgn, input logic mx);
    logic lt;
    if (sgn) begin
      lt = $signed(widen(x, bits, 1'b1)) < $signed(widen(y, bits, 1'b1));
    end else begin
      lt = x < y;
    end
    if (mx) begin
      return lt ? y : x;
    end
    return lt ? x : y;
  endfunction

  function automatic vreg_u ref_minmax(input vreg_u a, input vreg_u b, input eew_e e,
                                       input logic sgn, input logic mx);
    vreg_u r;
    r = '0;
    for (int i = 0; i < elem_count(e); i++) begin
      r = set_elem(r, e, i, pick(get_elem(a, e, i), get_elem(b, e, i), elem_bits(e), sgn, mx));
    end
    return r;
  endfunction

  function automatic vreg_u ref_splat(input logic [XLEN-1:0] v, input eew_e e);
    vreg_u r;
    r = '0;
    for (int i = 0; i < elem_count(e); i++) begin
      r = set_elem(r, e, i, v);
    end
    return r;
  endfunction

  function automatic vreg_u ref_merge(input vreg_u v0, input vreg_u s1, input vreg_u s2,
                                      input eew_e e, input logic [UOP_INDEX_WIDTH-1:0] idx);
    vreg_u           r;
    logic [VLEN-1:0] flat;
    int              n;
    r    = '0;
    flat = v0;
    n    = elem_count(e);
    for (int i = 0; i < n; i++) begin
      if (flat[int'(idx) * n + i]) begin
        r = set_elem(r, e, i, get_elem(s1, e, i));
      end else begin
        r = set_elem(r, e, i, get_elem(s2, e, i));
      end
    end
    return r;
  endfunction

  function automatic vreg_u ref_extend(input vreg_u src, input eew_e e, input int factor,
                                       input logic sgn, input logic [UOP_INDEX_WIDTH-1:0] idx);
    vreg_u r;
    eew_e  dst_e;
    int    base;
    r     = '0;
    dst_e = eew_e'(int'(e) + ((factor == 4) ? 2 : 1));
    base  = (int'(idx) % factor) * elem_count(dst_e);
    for (int i = 0; i < elem_count(dst_e); i++) begin
      r = set_elem(r, dst_e, i, widen(get_elem(src, e, base + i), elem_bits(e), sgn));
    end
    return r;
  endfunction

  function automatic vreg_u rand_vreg();
    vreg_u r;
    for (int i = 0; i < VLEN / WORD_WIDTH; i++) begin
      r.w[i] = $random(seed);
    end
    return r;
  endfunction

  // most negative, most positive, all ones and zero, rotated per operand
  function automatic vreg_u boundary_vreg(input eew_e e, input int rot);
    vreg_u       r;
    logic [31:0] vals[4];
    vals[0] = 32'd1 << (elem_bits(e) - 1);
    vals[1] = vals[0] - 32'd1;
    vals[2] = (32'd1 << elem_bits(e)) - 32'd1;
    vals[3] = 32'd0;
    r = '0;
    for (int i = 0; i < elem_count(e); i++) begin
      r = set_elem(r, e, i, vals[(i + rot) % 4]);
    end
    return r;
  endfunction

  task automatic check_vreg(input string name, input vreg_u exp, input vreg_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected valid %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_rob(input string name, input logic [ROB_ENTRY_WIDTH-1:0] exp,
                           input logic [ROB_ENTRY_WIDTH-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected rob %h, actual %h", name, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_uop(input funct3_e f3, input logic [FUNCT6_WIDTH-1:0] f6,
                           input logic [REG_INDEX_WIDTH-1:0] code, input logic mask_off,
                           input eew_e e, input logic [UOP_INDEX_WIDTH-1:0] idx);
    funct3    = f3;
    funct6    = f6;
    vs1       = code;
    vm        = mask_off;
    vs2_eew   = e;
    uop_index = idx;
    rob_entry = next_rob;
    next_rob  = next_rob + 1'b1;
    uop_valid = 1'b1;
  endtask

  task automatic check_result(input string name, input logic [ROB_ENTRY_WIDTH-1:0] rob,
                              input vreg_u exp);
    check_valid(name, 1'b1, result_valid);
    check_rob(name, rob, result_rob_entry);
    check_vreg(name, exp, result_data);
  endtask

  task automatic expect_result(input string name, input vreg_u exp);
    logic [ROB_ENTRY_WIDTH-1:0] rob;
    rob = rob_entry;
    next_cycle();
    check_result(name, rob, exp);
    uop_valid = 1'b0;
  endtask

  task automatic expect_no_result(input string name);
    next_cycle();
    check_valid(name, 1'b0, result_valid);
    uop_valid = 1'b0;
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_reset_state();
    int    err0;
    vreg_u zero;
    err0 = errors;
    zero = '0;
    check_valid("reset", 1'b0, result_valid);
    // a uop presented during reset must not come out
    vs1_data = rand_vreg();
    vs2_data = rand_vreg();
    // nonzero tag so a captured rob entry shows up
    next_rob = '1;
    drive_uop(OPIVV, VMAX, '0, 1'b1, EEW8, 3'd0);
    rst_n = 1'b0;
    next_cycle();
    check_valid("reset", 1'b0, result_valid);
    check_rob("reset", '0, result_rob_entry);
    check_vreg("reset", zero, result_data);
    rst_n     = 1'b1;
    uop_valid = 1'b0;
    report_test("reset", err0);
  endtask

  task automatic test_minmax(input logic scalar);
    int                      err0;
    eew_e                    e;
    logic [FUNCT6_WIDTH-1:0] f6;
    logic                    sgn;
    logic                    mx;
    vreg_u                   b;
    err0 = errors;
    for (int k = 0; k < 3; k++) begin
      e = eew_e'(k);
      for (int j = 0; j < 4; j++) begin
        f6  = VMINU + FUNCT6_WIDTH'(j);
        sgn = (f6 == VMIN) || (f6 == VMAX);
        mx  = (f6 == VMAXU) || (f6 == VMAX);
        for (int p = 0; p < 2; p++) begin
          if (p == 0) begin
            vs1_data = rand_vreg();
            vs2_data = rand_vreg();
            rs1_data = $random(seed);
          end else begin
            vs1_data = boundary_vreg(e, 0);
            vs2_data = boundary_vreg(e, 1);
            rs1_data = get_elem(boundary_vreg(e, 2), e, p);
          end
          b = scalar ? ref_splat(rs1_data, e) : vs1_data;
          drive_uop(scalar ? OPIVX : OPIVV, f6, '0, 1'b1, e, 3'd0);
          expect_result($sformatf("minmax eew%0d f6 %b scalar %b", elem_bits(e), f6, scalar),
                        ref_minmax(vs2_data, b, e, sgn, mx));
        end
      end
    end
    report_test(scalar ? "minmax_vx" : "minmax_vv", err0);
  endtask

  task automatic test_merge_move();
    int                         err0;
    eew_e                       e;
    logic [UOP_INDEX_WIDTH-1:0] idx;
    vreg_u                      s1;
    err0 = errors;
    for (int k = 0; k < 3; k++) begin
      e = eew_e'(k);
      for (int p = 0; p < 2; p++) begin
        idx      = (p == 0) ? 3'd0 : 3'd5;
        v0_data  = rand_vreg();
        vs1_data = rand_vreg();
        vs2_data = rand_vreg();
        rs1_data = $random(seed);
        s1       = (p == 0) ? vs1_data : ref_splat(rs1_data, e);
        drive_uop((p == 0) ? OPIVV : OPIVX, VMERGE_VMV, '0, 1'b0, e, idx);
        expect_result($sformatf("merge eew%0d idx %0d", elem_bits(e), idx),
                      ref_merge(v0_data, s1, vs2_data, e, idx));
        drive_uop((p == 0) ? OPIVV : OPIVX, VMERGE_VMV, '0, 1'b1, e, idx);
        expect_result($sformatf("move eew%0d idx %0d", elem_bits(e), idx), s1);
      end
    end
    report_test("merge_move", err0);
  endtask

  task automatic test_extend();
    int                         err0;
    int                         factor;
    eew_e                       e;
    logic [REG_INDEX_WIDTH-1:0] code;
    err0 = errors;
    for (int c = 0; c < 3; c++) begin
      factor = (c == 2) ? 4 : 2;
      e      = (c == 1) ? EEW16 : EEW8;
      for (int idx = 0; idx < factor; idx++) begin
        for (int s = 0; s < 2; s++) begin
          if (factor == 4) begin
            code = (s == 1) ? VSEXT_VF4 : VZEXT_VF4;
          end else begin
            code = (s == 1) ? VSEXT_VF2 : VZEXT_VF2;
          end
          vs2_data = rand_vreg();
          drive_uop(OPMVV, VXUNARY0, code, 1'b1, e, UOP_INDEX_WIDTH'(idx));
          expect_result($sformatf("extend vf%0d eew%0d idx %0d sign %0d",
                                  factor, elem_bits(e), idx, s),
                        ref_extend(vs2_data, e, factor, s[0], UOP_INDEX_WIDTH'(idx)));
        end
      end
    end
    report_test("extend", err0);
  endtask

  task automatic test_illegal();
    int err0;
    err0 = errors;
    drive_uop(OPMVV, VXUNARY0, VZEXT_VF4, 1'b1, EEW16, 3'd0);
    expect_no_result("illegal vf4 at eew16");
    drive_uop(OPMVV, VXUNARY0, VSEXT_VF2, 1'b1, EEW32, 3'd0);
    expect_no_result("illegal vf2 at eew32");
    drive_uop(OPIVV, 6'b000000, '0, 1'b1, EEW8, 3'd0);
    expect_no_result("unsupported funct6");
    report_test("illegal", err0);
  endtask

  task automatic test_back_to_back();
    int                         err0;
    vreg_u                      exp_a;
    vreg_u                      exp_b;
    vreg_u                      exp_c;
    logic [ROB_ENTRY_WIDTH-1:0] rob_a;
    logic [ROB_ENTRY_WIDTH-1:0] rob_b;
    logic [ROB_ENTRY_WIDTH-1:0] rob_c;
    err0     = errors;
    vs1_data = rand_vreg();
    vs2_data = rand_vreg();
    drive_uop(OPIVV, VMAXU, '0, 1'b1, EEW16, 3'd0);
    exp_a = ref_minmax(vs2_data, vs1_data, EEW16, 1'b0, 1'b1);
    rob_a = rob_entry;
    next_cycle();
    check_result("back_to_back first", rob_a, exp_a);
    vs2_data = rand_vreg();
    drive_uop(OPMVV, VXUNARY0, VSEXT_VF2, 1'b1, EEW8, 3'd1);
    exp_b = ref_extend(vs2_data, EEW8, 2, 1'b1, 3'd1);
    rob_b = rob_entry;
    next_cycle();
    check_result("back_to_back second", rob_b, exp_b);
    v0_data  = rand_vreg();
    vs1_data = rand_vreg();
    vs2_data = rand_vreg();
    drive_uop(OPIVV, VMERGE_VMV, '0, 1'b0, EEW32, 3'd2);
    exp_c = ref_merge(v0_data, vs1_data, vs2_data, EEW32, 3'd2);
    rob_c = rob_entry;
    next_cycle();
    check_result("back_to_back third", rob_c, exp_c);
    uop_valid = 1'b0;
    report_test("back_to_back", err0);
  endtask

  initial begin
    cycles       = 0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    next_rob     = '0;
    rst_n        = 1'b0;
    uop_valid    = 1'b0;
    vm           = 1'b1;
    funct3       = OPIVV;
    funct6       = '0;
    vs1          = '0;
    vs2_eew      = EEW8;
    uop_index    = '0;
    rob_entry    = '0;
    v0_data      = '0;
    vs1_data     = '0;
    vs2_data     = '0;
    rs1_data     = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_minmax(1'b0);
    test_minmax(1'b1);
    test_merge_move();
    test_extend();
    test_illegal();
    test_back_to_back();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/alu_other_pkg.sv
verilog/uop_ctrl_if.sv
verilog/alu_other_decode.sv
verilog/alu_operand_prep.sv
verilog/alu_minmax.sv
verilog/alu_extend.sv
verilog/alu_merge.sv
verilog/alu_result_stage.sv
verilog/alu_other_unit.sv
verif/alu_other_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = alu_other_tb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
